// File: src/rgbw_defs.svh
// RGBW LED controller shared constants
// frame length, PWM prescale and SPI synchronizer depth
`ifndef RGBW_DEFS_SVH
`define RGBW_DEFS_SVH

// seven bytes per colour frame from lint to mode
`define RGBW_FRAME_BYTES 7

// clk cycles per PWM counter tick
`define RGBW_PWM_PRESC 4

// flops on each SPI pin before use
`define RGBW_SYNC_STAGES 2

`endif

// File: src/rgbw_pkg.sv
// RGBW LED controller types
// colour frame, duty set and the fixed eight-entry palette
`default_nettype none

package rgbw_pkg;

    // one frame as received with the first byte in the top bits
    typedef struct packed {
        logic [7:0] lint;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
        logic [7:0] color_idx;
        logic [7:0] mode;
    } rgbw_frame_t;

    // per-channel PWM duty where 255 means always on
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
    } rgbw_duty_t;

    // index bits 0/1/2 light red/green/blue and white only lights on entry 7
    localparam rgbw_duty_t palette [8] = '{
        '{red: 8'h00, green: 8'h00, blue: 8'h00, white: 8'h00},
        '{red: 8'hff, green: 8'h00, blue: 8'h00, white: 8'h00},
        '{red: 8'h00, green: 8'hff, blue: 8'h00, white: 8'h00},
        '{red: 8'hff, green: 8'hff, blue: 8'h00, white: 8'h00},
        '{red: 8'h00, green: 8'h00, blue: 8'hff, white: 8'h00},
        '{red: 8'hff, green: 8'h00, blue: 8'hff, white: 8'h00},
        '{red: 8'h00, green: 8'hff, blue: 8'hff, white: 8'h00},
        '{red: 8'hff, green: 8'hff, blue: 8'hff, white: 8'hff}
    };

endpackage

`default_nettype wire

// File: src/rgbw_duty_if.sv
// duty update channel from the colour scaler to the PWM generator
// four duty bytes plus a one-cycle update strobe
`timescale 1ns/1ps
`default_nettype none

interface rgbw_duty_if;

    // new duty set that only counts with duty_valid
    rgbw_pkg::rgbw_duty_t duty;
    // single-cycle strobe without back-pressure
    logic                 duty_valid;

    // scaler side
    modport src (
        output duty,
        output duty_valid
    );

    // pwm side
    modport dst (
        input duty,
        input duty_valid
    );

endinterface

`default_nettype wire

// File: src/spi_rx.sv
// SPI mode-0 slave receiver
// oversamples sck, cs_n and mosi on clk and assembles MSB-first bytes
`timescale 1ns/1ps
`default_nettype none
`include "rgbw_defs.svh"

module spi_rx (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       sck,
    input  logic       cs_n,
    input  logic       mosi,
    output logic       byte_rdy,
    output logic [7:0] data_byte,
    output logic       frame_start
);

    // sync chains whose top bit is one cycle older than the synced value
    logic [`RGBW_SYNC_STAGES:0] sck_pipe;
    logic [`RGBW_SYNC_STAGES:0] cs_pipe;
    logic [`RGBW_SYNC_STAGES:0] mosi_pipe;

    logic       sck_rise;
    logic       cs_fall;
    logic       cs_high;
    logic       mosi_s;
    logic [2:0] bit_cnt;
    logic [6:0] shift_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sck_pipe  <= '0;
            // cs idles high so reset must not look like a falling edge
            cs_pipe   <= '1;
            mosi_pipe <= '0;
        end else begin
            sck_pipe  <= {sck_pipe[`RGBW_SYNC_STAGES-1:0], sck};
            cs_pipe   <= {cs_pipe[`RGBW_SYNC_STAGES-1:0], cs_n};
            mosi_pipe <= {mosi_pipe[`RGBW_SYNC_STAGES-1:0], mosi};
        end
    end

    assign sck_rise = sck_pipe[`RGBW_SYNC_STAGES-1] & ~sck_pipe[`RGBW_SYNC_STAGES];
    assign cs_fall  = ~cs_pipe[`RGBW_SYNC_STAGES-1] & cs_pipe[`RGBW_SYNC_STAGES];
    assign cs_high  = cs_pipe[`RGBW_SYNC_STAGES-1];
    // mosi from just before sck rose and settled since the last falling edge
    assign mosi_s   = mosi_pipe[`RGBW_SYNC_STAGES];

    // bit counter and strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt     <= 3'd0;
            byte_rdy    <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            byte_rdy    <= 1'b0;
            frame_start <= cs_fall;
            if (cs_high) begin
                // deselect drops any partial byte
                bit_cnt <= 3'd0;
            end else if (sck_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;
                byte_rdy <= (bit_cnt == 3'd7);
            end
        end
    end

    // shift register and byte output
    always_ff @(posedge clk) begin
        if (sck_rise && !cs_high) begin
            shift_q <= {shift_q[5:0], mosi_s};
            // eighth bit completes the byte
            if (bit_cnt == 3'd7) begin
                data_byte <= {shift_q, mosi_s};
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rgbw_frame_decoder.sv
// colour frame decoder
// collects the bytes of one chip-select frame and commits only complete frames
`timescale 1ns/1ps
`default_nettype none
`include "rgbw_defs.svh"

module rgbw_frame_decoder (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  byte_rdy,
    input  logic [7:0]            data_byte,
    input  logic                  frame_start,
    output rgbw_pkg::rgbw_frame_t frame,
    output logic                  frame_valid
);

    // index runs one past the last byte to mark the frame as done
    localparam int IDX_W   = $clog2(`RGBW_FRAME_BYTES + 1);
    localparam int FRAME_W = 8 * `RGBW_FRAME_BYTES;

    logic [IDX_W-1:0]   idx;
    // first bytes of the frame while the last one goes straight to the output
    logic [FRAME_W-9:0] shadow;
    logic               accept;
    logic               last_byte;

    // bytes beyond the frame length are ignored
    assign accept    = byte_rdy && (idx < IDX_W'(`RGBW_FRAME_BYTES));
    assign last_byte = (idx == IDX_W'(`RGBW_FRAME_BYTES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // no bytes taken until a chip select opens a frame
            idx         <= IDX_W'(`RGBW_FRAME_BYTES);
            frame       <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (frame_start) begin
                idx <= '0;
            end else if (accept) begin
                idx <= idx + 1'b1;
                // full frame so output and strobe change together
                if (last_byte) begin
                    frame       <= rgbw_pkg::rgbw_frame_t'({shadow, data_byte});
                    frame_valid <= 1'b1;
                end
            end
        end
    end

    // shifting keeps arrival order with the first byte in the top bits
    always_ff @(posedge clk) begin
        if (accept && !frame_start && !last_byte) begin
            shadow <= {shadow[FRAME_W-17:0], data_byte};
        end
    end

endmodule

`default_nettype wire

// File: src/color_scaler.sv
// colour source select and intensity scaling
// one shift-add multiplier shared by the four channels at nine cycles each
`timescale 1ns/1ps
`default_nettype none

module color_scaler (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rgbw_pkg::rgbw_frame_t frame,
    input  logic                  frame_valid,
    rgbw_duty_if.src              duty_out
);

    logic                 busy;
    logic [1:0]           ch;
    logic [3:0]           bit_idx;
    logic                 start;
    rgbw_pkg::rgbw_duty_t src_sel;
    rgbw_pkg::rgbw_duty_t src_q;
    logic [8:0]           factor_in;
    logic [8:0]           factor_q;
    logic [7:0]           mcand;
    logic                 fbit;
    logic [3:0]           shift;
    logic [15:0]          acc_base;
    logic [15:0]          acc_next;
    logic [15:0]          acc;
    logic [7:0]           res_red;
    logic [7:0]           res_green;
    logic [7:0]           res_blue;

    // palette when mode bit 0 is set and otherwise the frame bytes
    assign src_sel   = frame.mode[0] ? rgbw_pkg::palette[frame.color_idx[2:0]]
                                     : rgbw_pkg::rgbw_duty_t'{red: frame.red,
                                         green: frame.green, blue: frame.blue,
                                         white: frame.white};
    // lint 255 gives factor 256 so duty equals the byte
    assign factor_in = {1'b0, frame.lint} + 9'd1;
    // new frames while busy are dropped
    assign start     = frame_valid && !busy;

    // one multiplier step
    always_comb begin
        if (busy) begin
            case (ch)
                2'd0:    mcand = src_q.red;
                2'd1:    mcand = src_q.green;
                2'd2:    mcand = src_q.blue;
                default: mcand = src_q.white;
            endcase
            fbit     = factor_q[bit_idx];
            shift    = bit_idx;
            acc_base = (bit_idx == 4'd0) ? 16'd0 : acc;
        end else begin
            // bit 0 of red is done in the cycle the frame is taken
            mcand    = src_sel.red;
            fbit     = factor_in[0];
            shift    = 4'd0;
            acc_base = 16'd0;
        end
        acc_next = acc_base + (fbit ? ({8'd0, mcand} << shift) : 16'd0);
    end

    // channel and bit sequencing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy                <= 1'b0;
            ch                  <= 2'd0;
            bit_idx             <= 4'd0;
            duty_out.duty       <= '0;
            duty_out.duty_valid <= 1'b0;
        end else begin
            duty_out.duty_valid <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                ch      <= 2'd0;
                bit_idx <= 4'd1;
            end else if (busy) begin
                if (bit_idx == 4'd8) begin
                    bit_idx <= 4'd0;
                    ch      <= ch + 2'd1;
                    // white finished so all four go out at once
                    if (ch == 2'd3) begin
                        busy                <= 1'b0;
                        duty_out.duty       <= '{red: res_red, green: res_green,
                                                 blue: res_blue, white: acc_next[15:8]};
                        duty_out.duty_valid <= 1'b1;
                    end
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end
        end
    end

    // operands, accumulator and finished channels
    always_ff @(posedge clk) begin
        if (start) begin
            src_q    <= src_sel;
            factor_q <= factor_in;
        end
        if (start || busy) begin
            acc <= acc_next;
        end
        if (busy && bit_idx == 4'd8) begin
            case (ch)
                2'd0:    res_red   <= acc_next[15:8];
                2'd1:    res_green <= acc_next[15:8];
                2'd2:    res_blue  <= acc_next[15:8];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/pwm_gen.sv
// four-channel 8-bit PWM generator
// prescaled tick, period of 255 ticks, duty swapped at the period boundary
`timescale 1ns/1ps
`default_nettype none
`include "rgbw_defs.svh"

module pwm_gen (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     pwm_en,
    rgbw_duty_if.dst duty_in,
    output logic     red_pwm,
    output logic     green_pwm,
    output logic     blue_pwm,
    output logic     white_pwm
);

    localparam int PRESC_W = (`RGBW_PWM_PRESC > 1) ? $clog2(`RGBW_PWM_PRESC) : 1;

    logic [PRESC_W-1:0]   presc;
    logic                 tick;
    logic [7:0]           cnt;
    rgbw_pkg::rgbw_duty_t pending;
    rgbw_pkg::rgbw_duty_t active;

    assign tick = (presc == PRESC_W'(`RGBW_PWM_PRESC - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc     <= '0;
            cnt       <= 8'd0;
            pending   <= '0;
            active    <= '0;
            red_pwm   <= 1'b0;
            green_pwm <= 1'b0;
            blue_pwm  <= 1'b0;
            white_pwm <= 1'b0;
        end else begin
            // latest duty wins and applies at the next wrap
            if (duty_in.duty_valid) begin
                pending <= duty_in.duty;
            end
            if (!pwm_en) begin
                // disabled so the period is held at its start
                presc     <= '0;
                cnt       <= 8'd0;
                red_pwm   <= 1'b0;
                green_pwm <= 1'b0;
                blue_pwm  <= 1'b0;
                white_pwm <= 1'b0;
            end else begin
                presc <= tick ? '0 : presc + 1'b1;
                if (tick) begin
                    // counts 0..254 so duty 255 stays high for the whole period
                    if (cnt == 8'd254) begin
                        cnt    <= 8'd0;
                        active <= pending;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                red_pwm   <= (cnt < active.red);
                green_pwm <= (cnt < active.green);
                blue_pwm  <= (cnt < active.blue);
                white_pwm <= (cnt < active.white);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rgbw_controller.sv
// RGBW LED controller top level
// SPI receiver, frame decoder, colour scaler and PWM generator on one clock
`timescale 1ns/1ps
`default_nettype none

module rgbw_controller (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       sck,
    input  logic       cs_n,
    input  logic       mosi,
    input  logic       pwm_en,
    output logic       red_pwm,
    output logic       green_pwm,
    output logic       blue_pwm,
    output logic       white_pwm,
    output logic       byte_rdy,
    output logic [7:0] mode
);

    logic [7:0]            data_byte;
    logic                  frame_start;
    rgbw_pkg::rgbw_frame_t frame;
    logic                  frame_valid;

    // scaler to pwm duty channel
    rgbw_duty_if u_duty_if ();

    spi_rx u_spi_rx (
        .clk         (clk),
        .arst_n      (arst_n),
        .sck         (sck),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .byte_rdy    (byte_rdy),
        .data_byte   (data_byte),
        .frame_start (frame_start)
    );

    rgbw_frame_decoder u_rgbw_frame_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .byte_rdy    (byte_rdy),
        .data_byte   (data_byte),
        .frame_start (frame_start),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    color_scaler u_color_scaler (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame       (frame),
        .frame_valid (frame_valid),
        .duty_out    (u_duty_if)
    );

    pwm_gen u_pwm_gen (
        .clk       (clk),
        .arst_n    (arst_n),
        .pwm_en    (pwm_en),
        .duty_in   (u_duty_if),
        .red_pwm   (red_pwm),
        .green_pwm (green_pwm),
        .blue_pwm  (blue_pwm),
        .white_pwm (white_pwm)
    );

    // mode of the last complete frame
    assign mode = frame.mode;

endmodule

`default_nettype wire

// File: sim/rgbw_controller_asserts.sv
// assertion checker for the RGBW LED controller
// strobe widths and PWM outputs while disabled
`timescale 1ns/1ps
`default_nettype none

module rgbw_controller_asserts (
    input logic clk,
    input logic arst_n,
    input logic byte_rdy,
    input logic duty_valid,
    input logic pwm_en,
    input logic red_pwm,
    input logic green_pwm,
    input logic blue_pwm,
    input logic white_pwm
);

    logic any_pwm;

    assign any_pwm = red_pwm | green_pwm | blue_pwm | white_pwm;

    // byte strobe is a single cycle
    byte_rdy_single: assert property (
        @(posedge clk) disable iff (!arst_n) byte_rdy |=> !byte_rdy
    ) else $error("byte_rdy held high for more than one cycle");

    // registered outputs clear one cycle after the enable drops
    pwm_off_when_disabled: assert property (
        @(posedge clk) disable iff (!arst_n) !pwm_en |=> !any_pwm
    ) else $error("PWM output high while pwm_en is low");

    // duty update strobe on the scaler to pwm channel
    duty_valid_single: assert property (
        @(posedge clk) disable iff (!arst_n) duty_valid |=> !duty_valid
    ) else $error("duty_valid held high for more than one cycle");

endmodule

bind rgbw_controller rgbw_controller_asserts u_rgbw_controller_asserts (
    .clk        (clk),
    .arst_n     (arst_n),
    .byte_rdy   (byte_rdy),
    .duty_valid (u_duty_if.duty_valid),
    .pwm_en     (pwm_en),
    .red_pwm    (red_pwm),
    .green_pwm  (green_pwm),
    .blue_pwm   (blue_pwm),
    .white_pwm  (white_pwm)
);

`default_nettype wire

// File: sim/rgbw_controller_tb.sv
// testbench for the RGBW LED controller
// SPI frames in and duty measured at the LED pins over one PWM period
`timescale 1ns/1ps
`default_nettype none
`include "rgbw_defs.svh"

module rgbw_controller_tb;

    localparam int PERIOD  = 255 * `RGBW_PWM_PRESC;
    localparam int FBITS   = 8 * `RGBW_FRAME_BYTES;
    localparam int TIMEOUT = 200;

    logic                  clk;
    logic                  arst_n;
    logic                  sck;
    logic                  cs_n;
    logic                  mosi;
    logic                  pwm_en;
    logic                  red_pwm;
    logic                  green_pwm;
    logic                  blue_pwm;
    logic                  white_pwm;
    logic                  byte_rdy;
    logic [7:0]            mode;
    int                    errors = 0;
    int                    rdy_cnt = 0;
    logic [15:0]           lfsr;
    // last frame that was sent complete
    rgbw_pkg::rgbw_frame_t last_frame;

    rgbw_controller u_rgbw_controller (.*);

    always #4 clk = ~clk;

    // strobes counted mid-cycle away from the clock edge
    always @(negedge clk) begin
        if (byte_rdy) begin
            rdy_cnt = rdy_cnt + 1;
        end
    end

    // n rising edges and then 1 ns into the cycle
    task automatic cycles(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    // one step per bit taken
    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic rand_frame(output rgbw_pkg::rgbw_frame_t f);
        logic [FBITS-1:0] bits;
        logic [7:0]       b;
        for (int i = 0; i < `RGBW_FRAME_BYTES; i++) begin
            rand_byte(b);
            bits = {bits[FBITS-9:0], b};
        end
        f = bits;
    endtask

    // upper eight bits of byte times (lint + 1)
    function automatic logic [7:0] scale(logic [7:0] v, logic [7:0] lint);
        int p;
        p = int'(v) * (int'(lint) + 1);
        return 8'(p >> 8);
    endfunction

    function automatic rgbw_pkg::rgbw_duty_t expected_duty(rgbw_pkg::rgbw_frame_t f);
        rgbw_pkg::rgbw_duty_t src;
        rgbw_pkg::rgbw_duty_t d;
        logic [2:0]           idx;
        idx = f.color_idx[2:0];
        if (f.mode[0]) begin
            // index bits pick red, green and blue while white needs index 7
            src.red   = idx[0] ? 8'hff : 8'h00;
            src.green = idx[1] ? 8'hff : 8'h00;
            src.blue  = idx[2] ? 8'hff : 8'h00;
            src.white = (idx == 3'd7) ? 8'hff : 8'h00;
        end else begin
            src.red   = f.red;
            src.green = f.green;
            src.blue  = f.blue;
            src.white = f.white;
        end
        d.red   = scale(src.red, f.lint);
        d.green = scale(src.green, f.lint);
        d.blue  = scale(src.blue, f.lint);
        d.white = scale(src.white, f.lint);
        return d;
    endfunction

    task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_duty(string name, rgbw_pkg::rgbw_duty_t got,
                              rgbw_pkg::rgbw_duty_t exp);
        check_byte({name, ".red"}, got.red, exp.red);
        check_byte({name, ".green"}, got.green, exp.green);
        check_byte({name, ".blue"}, got.blue, exp.blue);
        check_byte({name, ".white"}, got.white, exp.white);
    endtask

    // SPI mode 0 with MSB first and sck at clk/8
    task automatic send_byte(logic [7:0] b);
        int i;
        int n;
        int target;
        target = rdy_cnt + 1;
        for (i = 7; i >= 0; i--) begin
            sck  = 1'b0;
            mosi = b[i];
            cycles(4);
            sck = 1'b1;
            cycles(4);
        end
        n = 0;
        while (rdy_cnt < target && n < TIMEOUT) begin
            cycles(1);
            n++;
        end
        if (rdy_cnt < target) begin
            $display("no byte_rdy for byte %h within %0d cycles at %0t", b, TIMEOUT, $time);
            errors++;
        end
    endtask

    // first nbytes of f inside one chip select with a strobe count check
    task automatic send_frame(rgbw_pkg::rgbw_frame_t f, int nbytes);
        logic [FBITS-1:0] bits;
        int               start;
        bits  = f;
        start = rdy_cnt;
        cs_n  = 1'b0;
        cycles(4);
        for (int i = 0; i < nbytes; i++) begin
            send_byte(bits[8*(`RGBW_FRAME_BYTES-1-i) +: 8]);
        end
        sck = 1'b0;
        cycles(4);
        cs_n = 1'b1;
        cycles(8);
        check_byte("byte_rdy count", 8'(rdy_cnt - start), 8'(nbytes));
    endtask

    // high cycles over exactly one period in PWM steps
    task automatic measure_duty(output rgbw_pkg::rgbw_duty_t d);
        int r;
        int g;
        int b;
        int w;
        r = 0;
        g = 0;
        b = 0;
        w = 0;
        repeat (PERIOD) begin
            @(negedge clk);
            r += int'(red_pwm);
            g += int'(green_pwm);
            b += int'(blue_pwm);
            w += int'(white_pwm);
        end
        d.red   = 8'(r / `RGBW_PWM_PRESC);
        d.green = 8'(g / `RGBW_PWM_PRESC);
        d.blue  = 8'(b / `RGBW_PWM_PRESC);
        d.white = 8'(w / `RGBW_PWM_PRESC);
        cycles(1);
    endtask

    // full frame followed by mode and duty checks after two periods
    task automatic apply_frame(rgbw_pkg::rgbw_frame_t f);
        rgbw_pkg::rgbw_duty_t d;
        send_frame(f, `RGBW_FRAME_BYTES);
        last_frame = f;
        check_byte("mode", mode, f.mode);
        cycles(2 * PERIOD);
        measure_duty(d);
        check_duty("duty", d, expected_duty(f));
    endtask

    task automatic reset_state();
        rgbw_pkg::rgbw_duty_t d;
        measure_duty(d);
        check_duty("reset duty", d, '0);
        check_byte("reset mode", mode, 8'h00);
        check_byte("reset byte_rdy count", 8'(rdy_cnt), 8'd0);
    endtask

    // fully random so the mode bit may pick either source
    task automatic byte_reception();
        rgbw_pkg::rgbw_frame_t f;
        rand_frame(f);
        apply_frame(f);
    endtask

    task automatic direct_scaling();
        rgbw_pkg::rgbw_frame_t f;
        for (int k = 0; k < 4; k++) begin
            rand_frame(f);
            f.mode[0] = 1'b0;
            // full and lowest intensity
            if (k == 2) begin
                f.lint = 8'hff;
            end
            if (k == 3) begin
                f.lint = 8'h00;
            end
            apply_frame(f);
        end
    endtask

    task automatic palette_scaling();
        rgbw_pkg::rgbw_frame_t f;
        for (int k = 0; k < 8; k++) begin
            rand_frame(f);
            f.color_idx[2:0] = 3'(k);
            f.mode[0]        = 1'b1;
            apply_frame(f);
        end
    endtask

    // cs_n high after four bytes keeps the old frame
    task automatic aborted_frame();
        rgbw_pkg::rgbw_frame_t f;
        rgbw_pkg::rgbw_duty_t  d;
        rand_frame(f);
        send_frame(f, 4);
        check_byte("mode after abort", mode, last_frame.mode);
        cycles(2 * PERIOD);
        measure_duty(d);
        check_duty("duty after abort", d, expected_duty(last_frame));
        rand_frame(f);
        apply_frame(f);
    endtask

    task automatic enable_toggle();
        rgbw_pkg::rgbw_frame_t f;
        rgbw_pkg::rgbw_duty_t  d;
        // direct frame at full intensity so the channels are lit
        rand_frame(f);
        f.mode[0] = 1'b0;
        f.lint    = 8'hff;
        apply_frame(f);
        pwm_en = 1'b0;
        cycles(2);
        measure_duty(d);
        check_duty("disabled duty", d, '0);
        pwm_en = 1'b1;
        cycles(2 * PERIOD);
        measure_duty(d);
        check_duty("enabled duty", d, expected_duty(last_frame));
    endtask

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        sck    = 1'b0;
        cs_n   = 1'b1;
        mosi   = 1'b0;
        pwm_en = 1'b1;
        lfsr   = 16'd26889;
        cycles(10);
        arst_n = 1'b1;
        cycles(2);
        reset_state();
        byte_reception();
        direct_scaling();
        palette_scaling();
        aborted_frame();
        enable_toggle();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // whole-run limit
    initial begin
        #2_000_000;
        $display("simulation time limit reached at %0t", $time);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rgbw_controller.f
+incdir+src
src/rgbw_pkg.sv
src/rgbw_duty_if.sv
src/spi_rx.sv
src/rgbw_frame_decoder.sv
src/color_scaler.sv
src/pwm_gen.sv
src/rgbw_controller.sv
sim/rgbw_controller_asserts.sv
sim/rgbw_controller_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the RGBW controller simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f rgbw_controller.f --top-module rgbw_controller_tb \
    -o rgbw_controller_sim || { echo "build failed"; exit 1; }

out="$(./obj_dir/rgbw_controller_sim)"
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
